// ==== Bender.yml ====
package:
  name: rv_decode_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_decode_pkg.sv
      - src/decode_ctrl_if.sv
      - src/instruction_decoder.sv
      - src/register_file.sv
      - src/immediate_generator.sv
      - src/decode_stage.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/decode_stage_tb.sv

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int N_RAND = 80;
    // reset, register loads, class sweep and nine random groups, four times over.
    localparam int MAX_CYCLES = 4 * (2 + 31 + 13 + 9 * N_RAND);

    typedef struct packed {
        logic [2:0]  fmt;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic        we;
        logic        ill;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] imm;
    } result_t;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic        wb_enable;
    logic        out_valid;
    logic        rd_write_enable;
    logic        illegal;
    logic [2:0]  format;
    logic [2:0]  funct3;
    logic [4:0]  wb_index;
    logic [4:0]  rd_index;
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [31:0] instruction;
    logic [31:0] wb_data;
    logic [31:0] operand_1;
    logic [31:0] operand_2;
    logic [31:0] immediate;
    logic [31:0] shadow [32];
    logic [31:0] rng;
    result_t     got;
    result_t     exp_next;
    result_t     exp_cur;
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          checks;
    int          issued;
    int          tests;
    int          cycles;

    tb_clock u_clock (.clk(clk));

    decode_stage UUT (.*);

    assign got = {format, opcode, funct3, funct7, rd_index, rd_write_enable, illegal,
                  operand_1, operand_2, immediate};

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected stage outputs for one strobe, shadow taken before the same-cycle write.
    function automatic result_t predict(input logic [31:0] i, input logic wen,
                                        input logic [4:0] widx, input logic [31:0] wdat);
        result_t    r;
        logic [2:0] en;
        r.fmt = rv_decode_pkg::FMT_NONE;
        if (i[1:0] == 2'b11) begin
            case (i[6:2])
                rv_decode_pkg::OP_LOAD, rv_decode_pkg::OP_LOAD_FP, rv_decode_pkg::OP_OP_IMM,
                rv_decode_pkg::OP_OP_IMM_32, rv_decode_pkg::OP_JALR:
                    r.fmt = rv_decode_pkg::FMT_I;
                rv_decode_pkg::OP_BRANCH: r.fmt = rv_decode_pkg::FMT_B;
                rv_decode_pkg::OP_STORE, rv_decode_pkg::OP_STORE_FP: r.fmt = rv_decode_pkg::FMT_S;
                rv_decode_pkg::OP_AUIPC, rv_decode_pkg::OP_LUI: r.fmt = rv_decode_pkg::FMT_U;
                rv_decode_pkg::OP_JAL: r.fmt = rv_decode_pkg::FMT_J;
                rv_decode_pkg::OP_OP, rv_decode_pkg::OP_OP_FP: r.fmt = rv_decode_pkg::FMT_R;
                default: r.fmt = rv_decode_pkg::FMT_NONE;
            endcase
        end
        // read 1, read 2, write.
        case (r.fmt)
            rv_decode_pkg::FMT_I: en = 3'b101;
            rv_decode_pkg::FMT_B, rv_decode_pkg::FMT_S: en = 3'b110;
            rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J: en = 3'b001;
            rv_decode_pkg::FMT_R: en = 3'b111;
            default: en = 3'b000;
        endcase
        case (r.fmt)
            rv_decode_pkg::FMT_I: r.imm = $signed({i[31:20], 20'h0}) >>> 20;
            rv_decode_pkg::FMT_S: r.imm = $signed({i[31:25], i[11:7], 20'h0}) >>> 20;
            rv_decode_pkg::FMT_B: r.imm = $signed({i[31], i[7], i[30:25], i[11:8], 20'h0}) >>> 19;
            rv_decode_pkg::FMT_U: r.imm = {i[31:12], 12'h000};
            rv_decode_pkg::FMT_J: r.imm = $signed({i[31], i[19:12], i[20], i[30:21], 12'h0}) >>> 11;
            default: r.imm = '0;
        endcase
        r.op1 = '0;
        r.op2 = '0;
        if (en[2] && i[19:15] != 5'd0) begin
            r.op1 = (wen && widx == i[19:15]) ? wdat : shadow[i[19:15]];
        end
        if (en[1] && i[24:20] != 5'd0) begin
            r.op2 = (wen && widx == i[24:20]) ? wdat : shadow[i[24:20]];
        end
        r.opcode = i[6:0];
        r.funct3 = i[14:12];
        r.funct7 = i[31:25];
        r.rd     = i[11:7];
        r.we     = en[0] && i[11:7] != 5'd0;
        r.ill    = (r.fmt == rv_decode_pkg::FMT_NONE);
        return r;
    endfunction

    task automatic drive(input logic valid, input logic [31:0] instr, input logic wen,
                         input logic [4:0] widx, input logic [31:0] wdat);
        @(posedge clk);
        if (valid) begin
            exp_next <= predict(instr, wen, widx, wdat);
            issued++;
        end
        instr_valid <= valid;
        instruction <= instr;
        wb_enable   <= wen;
        wb_index    <= widx;
        wb_data     <= wdat;
        if (wen && widx != 5'd0) begin
            shadow[widx] = wdat;
        end
    endtask

    task automatic finish_test();
        repeat (3) drive(1'b0, '0, 1'b0, '0, '0);
        tests++;
        $display("%s finished with %0d errors", test_name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // one-deep queue, the prediction moves along with its strobe.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (instr_valid) begin
            exp_cur <= exp_next;
        end
        if (arst_n && out_valid) begin
            checks <= checks + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before all tests finished", cycles);
            $display("Something failed");
            $finish;
        end
    end

    result_matches : assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> got == exp_cur
    ) else begin
        errors++;
        $display("Fail %s expected %h actual %h", test_name, $sampled(exp_cur), $sampled(got));
    end

    result_follows_strobe : assert property (
        @(posedge clk) disable iff (!arst_n) instr_valid |=> out_valid
    ) else begin
        errors++;
        $display("no result one cycle after a strobe in %s", test_name);
    end

    no_result_without_strobe : assert property (
        @(posedge clk) disable iff (!arst_n) !instr_valid |=> !out_valid
    ) else begin
        errors++;
        $display("result appeared without a strobe in %s", test_name);
    end

    initial begin
        rv_decode_pkg::opcode_e op;
        logic [31:0]            r;
        rng             = 32'h6dde_bfb2;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        issued          = 0;
        tests           = 0;
        cycles          = 0;
        arst_n          = 1'b0;
        instr_valid     = 1'b0;
        instruction     = '0;
        wb_enable       = 1'b0;
        wb_index        = '0;
        wb_data         = '0;
        exp_next        = '0;
        exp_cur         = '0;
        test_name       = "reset";
        for (int n = 0; n < 32; n++) begin
            shadow[n] = '0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 1; n < 32; n++) begin
            drive(1'b0, '0, 1'b1, 5'(n), next_rand());
        end

        test_name = "opcode_classes";
        op = op.first();
        do begin
            r = next_rand();
            drive(1'b1, {r[31:7], op, 2'b11}, 1'b0, '0, '0);
            op = op.next();
        end while (op != op.first());
        finish_test();

        // op keeps cycling through the classes, every fourth rd is x0.
        test_name = "field_extract";
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            if (n % 4 == 0) begin
                r[11:7] = '0;
            end
            drive(1'b1, {r[31:7], op, 2'b11}, 1'b0, '0, '0);
            op = op.next();
        end
        finish_test();

        test_name = "immediates";
        for (int n = 0; n < 5 * N_RAND; n++) begin
            r     = next_rand();
            r[31] = n[1];
            case (n % 5)
                0: r[6:2] = rv_decode_pkg::OP_OP_IMM;
                1: r[6:2] = rv_decode_pkg::OP_STORE;
                2: r[6:2] = rv_decode_pkg::OP_BRANCH;
                3: r[6:2] = rv_decode_pkg::OP_LUI;
                default: r[6:2] = rv_decode_pkg::OP_JAL;
            endcase
            r[1:0] = 2'b11;
            drive(1'b1, r, 1'b0, '0, '0);
        end
        finish_test();

        // R, I and U mix gives both, one and no enabled reads.
        test_name = "operands";
        // the x0 write lands together with a strobe that reads x0.
        drive(1'b1, {12'h0, 5'd0, 3'b000, 5'd1, rv_decode_pkg::OP_OP_IMM, 2'b11},
              1'b1, 5'd0, next_rand());
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            if (n % 8 == 0) begin
                r[19:15] = '0;
            end
            case (n % 3)
                0: r[6:0] = {rv_decode_pkg::OP_OP, 2'b11};
                1: r[6:0] = {rv_decode_pkg::OP_OP_IMM, 2'b11};
                default: r[6:0] = {rv_decode_pkg::OP_LUI, 2'b11};
            endcase
            drive(1'b1, r, 1'b0, '0, '0);
        end
        finish_test();

        test_name = "bypass_back_to_back";
        for (int n = 0; n < N_RAND; n++) begin
            r      = next_rand();
            r[6:0] = {rv_decode_pkg::OP_OP, 2'b11};
            drive(1'b1, r, 1'b1, (n % 2 == 0) ? r[19:15] : r[24:20], next_rand());
        end
        finish_test();

        test_name = "illegal";
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            if (n % 2 == 0) begin
                r[1:0] = 2'(n % 3);
            end else begin
                r[1:0] = 2'b11;
                // step to the next opcode that has no class.
                do begin
                    r[6:2] = r[6:2] + 5'd1;
                    op     = rv_decode_pkg::opcode_e'(r[6:2]);
                end while (op.name() != "");
            end
            drive(1'b1, r, 1'b0, '0, '0);
        end
        finish_test();

        if (checks != issued) begin
            errors++;
            $display("%0d strobes gave only %0d results", issued, checks);
        end
        $display("tests %0d, results checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 10 ns period, starting low.
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

interface decode_ctrl_if;

    logic [`RV_REG_IDX_W-1:0]     rs1_index;
    logic [`RV_REG_IDX_W-1:0]     rs2_index;
    logic [`RV_REG_IDX_W-1:0]     rd_index;
    logic                         read_enable_1;
    logic                         read_enable_2;
    logic                         write_enable;
    rv_decode_pkg::instr_format_e format;
    // high in the cycle an instruction is being decoded.
    logic                         decode_fire;

    modport decoder (
        output rs1_index,
        output rs2_index,
        output rd_index,
        output read_enable_1,
        output read_enable_2,
        output write_enable,
        output format,
        output decode_fire
    );

    modport regs (
        input rs1_index,
        input rs2_index,
        input read_enable_1,
        input read_enable_2,
        input decode_fire
    );

    modport imm (
        input format,
        input decode_fire
    );

endinterface

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  logic [31:0]         instruction,
    input  logic                wb_enable,
    input  logic [4:0]          wb_index,
    input  logic [`RV_XLEN-1:0] wb_data,
    output logic                out_valid,
    output logic [2:0]          format,
    output logic [6:0]          opcode,
    output logic [2:0]          funct3,
    output logic [6:0]          funct7,
    output logic [4:0]          rd_index,
    output logic                rd_write_enable,
    output logic                illegal,
    output logic [`RV_XLEN-1:0] operand_1,
    output logic [`RV_XLEN-1:0] operand_2,
    output logic [`RV_XLEN-1:0] immediate
);

    // decoder requests shared with the datapath blocks.
    decode_ctrl_if ctrl ();

    instruction_decoder u_decoder (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr_valid     (instr_valid),
        .instruction     (instruction),
        .ctrl            (ctrl.decoder),
        .out_valid       (out_valid),
        .format          (format),
        .opcode          (opcode),
        .funct3          (funct3),
        .funct7          (funct7),
        .rd_index        (rd_index),
        .rd_write_enable (rd_write_enable),
        .illegal         (illegal)
    );

    register_file u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl.regs),
        .wb_enable (wb_enable),
        .wb_index  (wb_index),
        .wb_data   (wb_data),
        .operand_1 (operand_1),
        .operand_2 (operand_2)
    );

    immediate_generator u_imm (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl.imm),
        .instruction (instruction),
        .immediate   (immediate)
    );

endmodule

`default_nettype wire

// ==== src/immediate_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module immediate_generator (
    input  logic                clk,
    input  logic                arst_n,
    decode_ctrl_if.imm          ctrl,
    input  logic [31:0]         instruction,
    output logic [`RV_XLEN-1:0] immediate
);

    logic [`RV_XLEN-1:0] imm_next;

    // bit 31 is the sign for every format that has an immediate.
    always_comb begin
        case (ctrl.format)
            rv_decode_pkg::FMT_I: begin
                imm_next = {{20{instruction[31]}}, instruction[31:20]};
            end
            rv_decode_pkg::FMT_S: begin
                imm_next = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            rv_decode_pkg::FMT_B: begin
                imm_next = {{19{instruction[31]}}, instruction[31], instruction[7],
                            instruction[30:25], instruction[11:8], 1'b0};
            end
            rv_decode_pkg::FMT_U: begin
                imm_next = {instruction[31:12], 12'b0};
            end
            rv_decode_pkg::FMT_J: begin
                imm_next = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                            instruction[20], instruction[30:21], 1'b0};
            end
            // R type and illegal encodings carry no immediate.
            default: begin
                imm_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            immediate <= '0;
        end else if (ctrl.decode_fire) begin
            immediate <= imm_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module instruction_decoder (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         instr_valid,
    input  logic [31:0]                  instruction,
    decode_ctrl_if.decoder               ctrl,
    output logic                         out_valid,
    output rv_decode_pkg::instr_format_e format,
    output logic [6:0]                   opcode,
    output logic [2:0]                   funct3,
    output logic [6:0]                   funct7,
    output logic [4:0]                   rd_index,
    output logic                         rd_write_enable,
    output logic                         illegal
);

    rv_decode_pkg::instr_format_e fmt;

    // opcode class to format, only for 32-bit encodings.
    always_comb begin
        fmt = rv_decode_pkg::FMT_NONE;
        if (instruction[1:0] == 2'b11) begin
            case (rv_decode_pkg::opcode_e'(instruction[6:2]))
                rv_decode_pkg::OP_LOAD,
                rv_decode_pkg::OP_LOAD_FP,
                rv_decode_pkg::OP_OP_IMM,
                rv_decode_pkg::OP_OP_IMM_32,
                rv_decode_pkg::OP_JALR:     fmt = rv_decode_pkg::FMT_I;
                rv_decode_pkg::OP_BRANCH:   fmt = rv_decode_pkg::FMT_B;
                rv_decode_pkg::OP_STORE,
                rv_decode_pkg::OP_STORE_FP: fmt = rv_decode_pkg::FMT_S;
                rv_decode_pkg::OP_AUIPC,
                rv_decode_pkg::OP_LUI:      fmt = rv_decode_pkg::FMT_U;
                rv_decode_pkg::OP_JAL:      fmt = rv_decode_pkg::FMT_J;
                rv_decode_pkg::OP_OP,
                rv_decode_pkg::OP_OP_FP:    fmt = rv_decode_pkg::FMT_R;
                default:                    fmt = rv_decode_pkg::FMT_NONE;
            endcase
        end
    end

    // register file requests toward the datapath.
    always_comb begin
        ctrl.decode_fire = instr_valid;
        ctrl.format      = fmt;
        ctrl.rs1_index   = instruction[19:15];
        ctrl.rs2_index   = instruction[24:20];
        ctrl.rd_index    = instruction[11:7];
        case (fmt)
            rv_decode_pkg::FMT_I: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b101;
            rv_decode_pkg::FMT_B: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b110;
            rv_decode_pkg::FMT_S: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b110;
            rv_decode_pkg::FMT_U: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b001;
            rv_decode_pkg::FMT_J: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b001;
            rv_decode_pkg::FMT_R: {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b111;
            default:              {ctrl.read_enable_1, ctrl.read_enable_2, ctrl.write_enable} = 3'b000;
        endcase
        // writes to x0 are dropped here.
        if (instruction[11:7] == '0) begin
            ctrl.write_enable = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid       <= 1'b0;
            format          <= rv_decode_pkg::FMT_I;
            opcode          <= '0;
            funct3          <= '0;
            funct7          <= '0;
            rd_index        <= '0;
            rd_write_enable <= 1'b0;
            illegal         <= 1'b0;
        end else begin
            out_valid <= instr_valid;
            if (instr_valid) begin
                format          <= ctrl.format;
                opcode          <= instruction[6:0];
                funct3          <= instruction[14:12];
                funct7          <= instruction[31:25];
                rd_index        <= ctrl.rd_index;
                rd_write_enable <= ctrl.write_enable;
                illegal         <= (ctrl.format == rv_decode_pkg::FMT_NONE);
            end
        end
    end

    // an illegal instruction never commits a register write.
    illegal_no_write : assert property (
        @(posedge clk) disable iff (!arst_n) illegal |-> !rd_write_enable
    );

    // no result appears without a strobe one cycle earlier.
    valid_needs_strobe : assert property (
        @(posedge clk) disable iff (!arst_n) !instr_valid |=> !out_valid
    );

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module register_file (
    input  logic                   clk,
    input  logic                   arst_n,
    decode_ctrl_if.regs            ctrl,
    input  logic                   wb_enable,
    input  logic [4:0]             wb_index,
    input  logic [`RV_XLEN-1:0]    wb_data,
    output logic [`RV_XLEN-1:0]    operand_1,
    output logic [`RV_XLEN-1:0]    operand_2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // read value for one port, with the same-cycle writeback forwarded.
    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic                     enable,
        input logic [`RV_REG_IDX_W-1:0] index
    );
        logic [`RV_XLEN-1:0] value;
        if (!enable || index == '0) begin
            value = '0;
        end else if (wb_enable && wb_index == index) begin
            value = wb_data;
        end else begin
            value = regs[index];
        end
        return value;
    endfunction

    // entry 0 is never written, so it stays at its reset value.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && wb_index != '0) begin
            regs[wb_index] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_1 <= '0;
            operand_2 <= '0;
        end else if (ctrl.decode_fire) begin
            operand_1 <= read_port(ctrl.read_enable_1, ctrl.rs1_index);
            operand_2 <= read_port(ctrl.read_enable_2, ctrl.rs2_index);
        end
    end

    // x0 storage must hold zero whatever the writeback port does.
    x0_stays_zero : assert property (
        @(posedge clk) disable iff (!arst_n) regs[0] == '0
    );

endmodule

`default_nettype wire

// ==== src/rv_decode_params.svh ====
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// data width of operands, immediates and writeback.
`define RV_XLEN 32

// architectural register count and the index width that addresses it.
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

`endif

// ==== src/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    // instruction format as seen by the immediate generator.
    typedef enum logic [2:0] {
        FMT_I    = 3'd0,
        FMT_B    = 3'd1,
        FMT_S    = 3'd2,
        FMT_U    = 3'd3,
        FMT_J    = 3'd4,
        FMT_R    = 3'd5,
        FMT_NONE = 3'd6
    } instr_format_e;

    // major opcode classes, instruction bits 6 to 2.
    // bits 1 to 0 must be 11 for a 32-bit encoding.
    typedef enum logic [4:0] {
        OP_LOAD      = 5'b00000,
        OP_LOAD_FP   = 5'b00001,
        OP_OP_IMM    = 5'b00100,
        OP_AUIPC     = 5'b00101,
        OP_OP_IMM_32 = 5'b00110,
        OP_STORE     = 5'b01000,
        OP_STORE_FP  = 5'b01001,
        OP_OP        = 5'b01100,
        OP_LUI       = 5'b01101,
        OP_OP_FP     = 5'b10100,
        OP_BRANCH    = 5'b11000,
        OP_JALR      = 5'b11001,
        OP_JAL       = 5'b11011
    } opcode_e;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/rv_decode_pkg.sv
src/decode_ctrl_if.sv
src/instruction_decoder.sv
src/register_file.sv
src/immediate_generator.sv
src/decode_stage.sv
sim/tb_clock.sv
sim/decode_stage_tb.sv
